/* verif/serial_slave_vectors.txt */
// columns, all hex: op id addr count gap word0 word1 word2 word3
// op 1 write, 2 burst write, 3 read (word0 expected), 4 write with foreign id, 0 end
1 1 10 1 0 deadbeef 00000000 00000000 00000000
3 1 10 1 0 deadbeef 00000000 00000000 00000000
1 1 23 1 0 00000011 00000000 00000000 00000000
2 1 20 3 0 a5a50001 5a5a0002 80000003 00000000
3 1 20 1 0 a5a50001 00000000 00000000 00000000
3 1 21 1 0 5a5a0002 00000000 00000000 00000000
3 1 22 1 0 80000003 00000000 00000000 00000000
3 1 23 1 0 00000011 00000000 00000000 00000000
1 1 40 1 0 cafef00d 00000000 00000000 00000000
4 2 40 1 0 0bad0bad 00000000 00000000 00000000
4 3 40 1 1 feedface 00000000 00000000 00000000
3 1 40 1 0 cafef00d 00000000 00000000 00000000
1 1 50 1 1 12345678 00000000 00000000 00000000
1 1 51 1 0 12345678 00000000 00000000 00000000
3 1 50 1 0 12345678 00000000 00000000 00000000
3 1 51 1 0 12345678 00000000 00000000 00000000
2 1 fe 3 1 01234567 89abcdef 76543210 00000000
3 1 fe 1 0 01234567 00000000 00000000 00000000
3 1 ff 1 0 89abcdef 00000000 00000000 00000000
3 1 00 1 0 76543210 00000000 00000000 00000000
0 0 00 0 0 00000000 00000000 00000000 00000000

/* compile.f */
verilog/serial_slave_pkg.sv
verilog/slave_ctrl_if.sv
verilog/frame_receiver.sv
verilog/bit_counter.sv
verilog/slave_fsm.sv
verilog/read_serializer.sv
verilog/write_deserializer.sv
verilog/word_memory.sv
verilog/serial_slave_top.sv
verif/tb_clock_gen.sv
verif/serial_slave_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the serial slave testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps -f compile.f --top-module serial_slave_tb \
    -o serial_slave_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

output=$(./obj_dir/serial_slave_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
echo "pass message not found in the simulation output"
exit 1

/* verif/serial_slave_tb.sv */
/* Testbench of the serial bus slave, driven by verif/serial_slave_vectors.txt.
   Sends frames and data on falling edges and checks ready, rd and rd_valid. */
`default_nettype none

module serial_slave_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import serial_slave_pkg::*;

    localparam slave_id_t SLAVE_ID   = 2'd1;
    localparam int        MEM_DEPTH  = 256;
    localparam int        REC_WORDS  = 9;
    localparam int        MAX_TESTS  = 32;
    localparam int        MAX_BURST  = 4;
    localparam int        WAIT_LIMIT = 64;

    // operation codes of the vector file
    localparam int OP_END     = 0;
    localparam int OP_WRITE   = 1;
    localparam int OP_BURST   = 2;
    localparam int OP_READ    = 3;
    localparam int OP_FOREIGN = 4;

    logic clk;
    logic rstN;
    logic control;
    logic wd;
    logic valid;
    logic last;
    logic rd;
    logic rd_valid;
    logic ready;

    logic [31:0] vectors [REC_WORDS * MAX_TESTS];
    string       test_name;
    int          test_errors;
    int          errors;
    int          checks;
    int          tests;
    bit          timed_out;

    tb_clock_gen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (4)
    ) tb_clock_gen_i (
        .clk  (clk),
        .rstN (rstN)
    );

    serial_slave_top #(
        .SLAVE_ID  (SLAVE_ID),
        .MEM_DEPTH (MEM_DEPTH)
    ) serial_slave_top_i (
        .clk      (clk),
        .rstN     (rstN),
        .control  (control),
        .wd       (wd),
        .valid    (valid),
        .last     (last),
        .rd       (rd),
        .rd_valid (rd_valid),
        .ready    (ready)
    );

    task automatic check_data(input string what, input data_t expected, input data_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("FAIL %s %s expected %08h actual %08h", test_name, what, expected, actual);
        end
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            test_errors++;
            $display("FAIL %s %s expected %b actual %b", test_name, what, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("ERROR in %s: %s before the timeout", test_name, what);
        timed_out = 1'b1;
    endtask

    task automatic wait_for_ready(input int limit, input bit quiet_rd);
        int n;
        n = 0;
        while (ready !== 1'b1 && n < limit) begin
            if (quiet_rd) begin
                check_bit("rd_valid while busy", 1'b0, rd_valid);
            end
            @(negedge clk);
            n++;
        end
        if (ready !== 1'b1) begin
            report_timeout("ready did not return high");
        end
    endtask

    // frame bits go out msb first, one per cycle
    task automatic send_frame(input slave_id_t id, input logic write, input logic burst,
                              input addr_t addr);
        logic [FRAME_BITS-1:0] frame;
        frame = {{START_BITS{1'b1}}, id, write, burst, addr};
        wait_for_ready(WAIT_LIMIT, 1'b0);
        if (timed_out) begin
            return;
        end
        for (int i = FRAME_BITS - 1; i >= 0; i--) begin
            control = frame[i];
            @(negedge clk);
        end
        control = 1'b0;
        check_bit("ready after frame", 1'b0, ready);
    endtask

    task automatic send_word(input data_t word, input bit gap, input bit last_word);
        int n;
        for (int i = DATA_WIDTH - 1; i >= 0; i--) begin
            if (gap) begin
                n = $urandom_range(0, 3);
                // junk on wd while valid is low
                repeat (n) begin
                    valid = 1'b0;
                    last  = 1'b0;
                    wd    = 1'($urandom_range(0, 1));
                    @(negedge clk);
                end
            end
            valid = 1'b1;
            wd    = word[i];
            last  = last_word && (i == 0);
            @(negedge clk);
        end
        valid = 1'b0;
        wd    = 1'b0;
        last  = 1'b0;
    endtask

    task automatic write_words(input slave_id_t id, input addr_t addr, input int count,
                               input bit burst, input bit gap, input data_t words [MAX_BURST]);
        send_frame(id, 1'b1, burst, addr);
        if (timed_out) begin
            return;
        end
        // the decode cycle passes before the first data bit
        @(negedge clk);
        for (int w = 0; w < count; w++) begin
            send_word(words[w], gap, w == count - 1);
        end
        wait_for_ready(WAIT_LIMIT, 1'b1);
    endtask

    task automatic foreign_write(input slave_id_t id, input addr_t addr, input bit gap,
                                 input data_t word);
        send_frame(id, 1'b1, 1'b0, addr);
        if (timed_out) begin
            return;
        end
        wait_for_ready(2, 1'b1);
        if (timed_out) begin
            return;
        end
        send_word(word, gap, 1'b1);
        check_bit("ready after ignored data", 1'b1, ready);
        check_bit("rd_valid after ignored data", 1'b0, rd_valid);
    endtask

    task automatic read_word(input slave_id_t id, input addr_t addr, input data_t expected);
        data_t got;
        int    n;
        send_frame(id, 1'b0, 1'b0, addr);
        if (timed_out) begin
            return;
        end
        n = 0;
        while (rd_valid !== 1'b1 && n < WAIT_LIMIT) begin
            check_bit("ready before read data", 1'b0, ready);
            @(negedge clk);
            n++;
        end
        if (rd_valid !== 1'b1) begin
            report_timeout("rd_valid never rose for the read");
            return;
        end
        for (int i = DATA_WIDTH - 1; i >= 0; i--) begin
            check_bit("rd_valid during word", 1'b1, rd_valid);
            check_bit("ready during word", 1'b0, ready);
            got[i] = rd;
            @(negedge clk);
        end
        check_bit("rd_valid after word", 1'b0, rd_valid);
        check_data("read word", expected, got);
        wait_for_ready(WAIT_LIMIT, 1'b1);
    endtask

    task automatic report_test();
        tests++;
        if (test_errors == 0 && !timed_out) begin
            $display("test %s ok", test_name);
        end else begin
            $display("test %s done with %0d mismatches", test_name, test_errors);
        end
    endtask

    task automatic run_test(input int idx, input int base);
        int        op;
        slave_id_t id;
        addr_t     addr;
        int        count;
        bit        gap;
        data_t     words [MAX_BURST];
        string     op_name;
        op    = int'(vectors[base]);
        id    = slave_id_t'(vectors[base + 1]);
        addr  = addr_t'(vectors[base + 2]);
        count = int'(vectors[base + 3]);
        gap   = vectors[base + 4][0];
        for (int k = 0; k < MAX_BURST; k++) begin
            words[k] = vectors[base + 5 + k];
        end
        case (op)
            OP_WRITE:   op_name = "write";
            OP_BURST:   op_name = "burst";
            OP_READ:    op_name = "read";
            OP_FOREIGN: op_name = "foreign";
            default:    op_name = "unknown";
        endcase
        test_name   = $sformatf("t%0d_%s_%02h", idx, op_name, addr);
        test_errors = 0;
        if (count < 1 || count > MAX_BURST) begin
            $display("ERROR in %s: word count %0d in the vectors is out of range",
                     test_name, count);
            errors++;
            test_errors++;
        end else begin
            case (op)
                OP_WRITE:   write_words(id, addr, 1, 1'b0, gap, words);
                OP_BURST:   write_words(id, addr, count, 1'b1, gap, words);
                OP_READ:    read_word(id, addr, words[0]);
                OP_FOREIGN: foreign_write(id, addr, gap, words[0]);
                default: begin
                    $display("ERROR in %s: unknown operation code %0d", test_name, op);
                    errors++;
                    test_errors++;
                end
            endcase
        end
        report_test();
    endtask

    initial begin
        int n;
        control   = 1'b0;
        wd        = 1'b0;
        valid     = 1'b0;
        last      = 1'b0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        timed_out = 1'b0;
        void'($urandom(32'hf44f_f172));
        foreach (vectors[k]) begin
            vectors[k] = '0;
        end
        $readmemh("verif/serial_slave_vectors.txt", vectors);

        test_name   = "reset";
        test_errors = 0;
        n = 0;
        while (rstN !== 1'b1 && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (rstN !== 1'b1) begin
            report_timeout("reset was never released");
        end
        @(negedge clk);
        check_bit("ready after reset", 1'b1, ready);
        check_bit("rd_valid after reset", 1'b0, rd_valid);
        check_bit("rd after reset", 1'b0, rd);
        report_test();

        for (int t = 0; t < MAX_TESTS && !timed_out; t++) begin
            if (vectors[t * REC_WORDS] == OP_END) begin
                break;
            end
            run_test(t, t * REC_WORDS);
        end
        if (tests < 2) begin
            $display("ERROR: no tests were read from the vector file");
            errors++;
        end

        $display("tests %0d, checks %0d, mismatches %0d, timeout %0d",
                 tests, checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
/* Clock and reset source for the serial slave testbench.
   Reset is held low for RESET_CYCLES clock periods and released on a falling edge. */
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rstN
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release away from the rising edge
    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

/* verilog/serial_slave_top.sv */
/* Top level of the serial bus slave with plain ports toward the master.
   Connects the FSM, the bit counter and the data path over the command interface. */
`default_nettype none

module serial_slave_top #(
    parameter serial_slave_pkg::slave_id_t SLAVE_ID  = 2'd1,
    parameter int                          MEM_DEPTH = 256
) (
    input  wire logic clk,
    input  wire logic rstN,
    input  wire logic control,
    input  wire logic wd,
    input  wire logic valid,
    input  wire logic last,
    output logic      rd,
    output logic      rd_valid,
    output logic      ready
);
    import serial_slave_pkg::*;

    logic        frame_match;
    logic        frame_write;
    logic        frame_burst;
    addr_t       frame_address;
    logic        count_en;
    logic        count_done;
    count_mode_t count_mode;
    data_t       mem_rdata;
    data_t       wr_word;

    slave_ctrl_if ctrl_if ();

    slave_fsm slave_fsm_i (
        .clk         (clk),
        .rstN        (rstN),
        .control     (control),
        .valid       (valid),
        .last        (last),
        .frame_match (frame_match),
        .frame_write (frame_write),
        .frame_burst (frame_burst),
        .count_done  (count_done),
        .count_en    (count_en),
        .count_mode  (count_mode),
        .ready       (ready),
        .ctrl        (ctrl_if.fsm)
    );

    bit_counter bit_counter_i (
        .clk    (clk),
        .rstN   (rstN),
        .enable (count_en),
        .mode   (count_mode),
        .done   (count_done)
    );

    frame_receiver #(
        .SLAVE_ID (SLAVE_ID)
    ) frame_receiver_i (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .ctrl    (ctrl_if.frame),
        .match   (frame_match),
        .write   (frame_write),
        .burst   (frame_burst),
        .address (frame_address)
    );

    read_serializer read_serializer_i (
        .clk      (clk),
        .rstN     (rstN),
        .ctrl     (ctrl_if.reader),
        .word     (mem_rdata),
        .rd       (rd),
        .rd_valid (rd_valid)
    );

    write_deserializer write_deserializer_i (
        .clk  (clk),
        .rstN (rstN),
        .ctrl (ctrl_if.writer),
        .wd   (wd),
        .word (wr_word)
    );

    word_memory #(
        .MEM_DEPTH (MEM_DEPTH)
    ) word_memory_i (
        .clk           (clk),
        .rstN          (rstN),
        .ctrl          (ctrl_if.memory),
        .frame_address (frame_address),
        .wdata         (wr_word),
        .rdata         (mem_rdata)
    );

endmodule

`default_nettype wire

/* verilog/word_memory.sv */
/* Word array of the slave with its address register.
   Read data is registered from the current address; writes use the same address. */
`default_nettype none

module word_memory #(
    parameter int MEM_DEPTH = 256
) (
    input  wire logic                   clk,
    input  wire logic                   rstN,
    slave_ctrl_if.memory                ctrl,
    input  serial_slave_pkg::addr_t     frame_address,
    input  serial_slave_pkg::data_t     wdata,
    output serial_slave_pkg::data_t     rdata
);
    import serial_slave_pkg::*;

    data_t mem [MEM_DEPTH];
    addr_t mem_addr;
    addr_t addr_next;

    // wraps at the top of the array
    assign addr_next = (mem_addr == addr_t'(MEM_DEPTH - 1)) ? '0 : mem_addr + 1'b1;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mem_addr <= '0;
        end else if (ctrl.addr_load) begin
            mem_addr <= addr_t'(frame_address % MEM_DEPTH);
        end else if (ctrl.addr_inc) begin
            mem_addr <= addr_next;
        end
    end

    // a write and an increment in the same cycle store at the old address
    always_ff @(posedge clk) begin
        if (ctrl.mem_write) begin
            mem[mem_addr] <= wdata;
        end
        rdata <= mem[mem_addr];
    end

endmodule

`default_nettype wire

/* verilog/write_deserializer.sv */
/* Serial to parallel converter for write data.
   Bits arrive MSB first and enter at the LSB on every wd_shift. */
`default_nettype none

module write_deserializer (
    input  wire logic                   clk,
    input  wire logic                   rstN,
    slave_ctrl_if.writer                ctrl,
    input  wire logic                   wd,
    output serial_slave_pkg::data_t     word
);
    import serial_slave_pkg::*;

    data_t word_q;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            word_q <= '0;
        end else if (ctrl.wd_shift) begin
            // after 32 shifts the first bit sits at the MSB
            word_q <= {word_q[DATA_WIDTH-2:0], wd};
        end
    end

    assign word = word_q;

endmodule

`default_nettype wire

/* verilog/read_serializer.sv */
/* Parallel to serial converter for read data.
   rd_load grabs a memory word, each rd_shift puts the next MSB on rd one cycle later. */
`default_nettype none

module read_serializer (
    input  wire logic                   clk,
    input  wire logic                   rstN,
    slave_ctrl_if.reader                ctrl,
    input  serial_slave_pkg::data_t     word,
    output logic                        rd,
    output logic                        rd_valid
);
    import serial_slave_pkg::*;

    data_t shift_q;

    always_ff @(posedge clk) begin
        if (ctrl.rd_load) begin
            shift_q <= word;
        end else if (ctrl.rd_shift) begin
            shift_q <= {shift_q[DATA_WIDTH-2:0], 1'b0};
        end
    end

    // rd stays low whenever rd_valid is low
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rd       <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            rd       <= ctrl.rd_shift && shift_q[DATA_WIDTH-1];
            rd_valid <= ctrl.rd_shift;
        end
    end

endmodule

`default_nettype wire

/* verilog/slave_fsm.sv */
/* Transaction FSM of the slave: frame intake, decode, single read and (burst) write.
   Drives ready, the bit counter and every data path command. */
`default_nettype none

module slave_fsm (
    input  wire logic                       clk,
    input  wire logic                       rstN,
    input  wire logic                       control,
    input  wire logic                       valid,
    input  wire logic                       last,
    input  wire logic                       frame_match,
    input  wire logic                       frame_write,
    input  wire logic                       frame_burst,
    input  wire logic                       count_done,
    output logic                            count_en,
    output serial_slave_pkg::count_mode_t   count_mode,
    output logic                            ready,
    slave_ctrl_if.fsm                       ctrl
);
    import serial_slave_pkg::*;

    slave_state_t state;
    slave_state_t state_next;
    logic         last_seen;
    logic         read_tail;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= IDLE;
            last_seen <= 1'b0;
            read_tail <= 1'b0;
        end else begin
            state     <= state_next;
            // last is sampled with the final valid bit of each word
            if (state == WRITE_SHIFT && count_done) begin
                last_seen <= last;
            end
            // holds ready low while the final read bit is still on rd
            read_tail <= (state == READ_SHIFT) && count_done;
        end
    end

    assign ready = ((state == IDLE) && !read_tail) || (state == FRAME);

    always_comb begin
        state_next       = state;
        count_en         = 1'b0;
        count_mode       = COUNT_WORD;
        ctrl.frame_shift = 1'b0;
        ctrl.addr_load   = 1'b0;
        ctrl.addr_inc    = 1'b0;
        ctrl.mem_write   = 1'b0;
        ctrl.rd_load     = 1'b0;
        ctrl.rd_shift    = 1'b0;
        ctrl.wd_shift    = 1'b0;
        case (state)
            IDLE: begin
                count_mode = COUNT_FRAME;
                // the first high control bit is already start bit one
                if (control && ready) begin
                    ctrl.frame_shift = 1'b1;
                    count_en         = 1'b1;
                    state_next       = FRAME;
                end
            end
            FRAME: begin
                count_mode       = COUNT_FRAME;
                ctrl.frame_shift = 1'b1;
                count_en         = 1'b1;
                if (count_done) begin
                    state_next = DECODE;
                end
            end
            DECODE: begin
                if (!frame_match) begin
                    state_next = IDLE;
                end else begin
                    ctrl.addr_load = 1'b1;
                    state_next     = frame_write ? WRITE_SHIFT : READ_FETCH;
                end
            end
            READ_FETCH: begin
                // registered memory read of the new address
                state_next = READ_LOAD;
            end
            READ_LOAD: begin
                ctrl.rd_load = 1'b1;
                state_next   = READ_SHIFT;
            end
            READ_SHIFT: begin
                ctrl.rd_shift = 1'b1;
                count_en      = 1'b1;
                if (count_done) begin
                    state_next = IDLE;
                end
            end
            WRITE_SHIFT: begin
                ctrl.wd_shift = valid;
                count_en      = valid;
                if (count_done) begin
                    state_next = WRITE_STORE;
                end
            end
            WRITE_STORE: begin
                ctrl.mem_write = 1'b1;
                if (frame_burst && !last_seen) begin
                    // next burst word may already start in this cycle
                    ctrl.addr_inc = 1'b1;
                    ctrl.wd_shift = valid;
                    count_en      = valid;
                    state_next    = WRITE_SHIFT;
                end else begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/bit_counter.sv */
/* Shared bit counter for frame bits and data bits.
   done marks the enabled cycle of the last bit, after which the count wraps. */
`default_nettype none

module bit_counter (
    input  wire logic                       clk,
    input  wire logic                       rstN,
    input  wire logic                       enable,
    input  serial_slave_pkg::count_mode_t   mode,
    output logic                            done
);
    import serial_slave_pkg::*;

    bit_count_t count;
    bit_count_t limit;

    always_comb begin
        if (mode == COUNT_FRAME) begin
            limit = bit_count_t'(FRAME_BITS - 1);
        end else begin
            limit = bit_count_t'(DATA_WIDTH - 1);
        end
    end

    assign done = enable && (count == limit);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
        end else if (enable) begin
            // wrap so the next frame or word starts from zero
            if (done) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/frame_receiver.sv */
/* Shifts in the serial control frame and decodes its fields.
   The decoded fields are stable from the cycle after the last shift. */
`default_nettype none

module frame_receiver #(
    parameter serial_slave_pkg::slave_id_t SLAVE_ID = 2'd1
) (
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  wire logic                   control,
    slave_ctrl_if.frame                 ctrl,
    output logic                        match,
    output logic                        write,
    output logic                        burst,
    output serial_slave_pkg::addr_t     address
);
    import serial_slave_pkg::*;

    logic [FRAME_BITS-1:0] frame_q;
    logic                  start_ok;
    slave_id_t             frame_id;

    // msb first on the line, so shift towards the msb
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            frame_q <= '0;
        end else if (ctrl.frame_shift) begin
            frame_q <= {frame_q[FRAME_BITS-2:0], control};
        end
    end

    assign start_ok = &frame_q[START_MSB:START_LSB];
    assign frame_id = frame_q[ID_MSB:ID_LSB];

    // a frame without all start bits set is treated like a foreign one
    assign match   = start_ok && (frame_id == SLAVE_ID);
    assign write   = frame_q[RW_POS];
    assign burst   = frame_q[BURST_POS];
    assign address = frame_q[ADDR_MSB:ADDR_LSB];

endmodule

`default_nettype wire

/* verilog/slave_ctrl_if.sv */
/* Command bundle from the slave FSM to the data path modules.
   Every command is active high and takes effect at the next rising edge. */
`default_nettype none

interface slave_ctrl_if;

    logic frame_shift;
    logic addr_load;
    logic addr_inc;
    logic mem_write;
    logic rd_load;
    logic rd_shift;
    logic wd_shift;

    modport fsm (
        output frame_shift, addr_load, addr_inc, mem_write,
        output rd_load, rd_shift, wd_shift
    );

    modport frame (input frame_shift);

    modport memory (input addr_load, addr_inc, mem_write);

    modport reader (input rd_load, rd_shift);

    modport writer (input wd_shift);

endinterface

`default_nettype wire

/* verilog/serial_slave_pkg.sv */
/* Shared widths, frame field positions, vector types and enums for the serial bus slave.
   Modules pull these in with a wildcard import inside their body. */
`default_nettype none

package serial_slave_pkg;

    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 8;
    localparam int ID_WIDTH   = 2;
    localparam int START_BITS = 3;

    // start bits, slave id, rw bit, burst bit, word address
    localparam int FRAME_BITS = START_BITS + ID_WIDTH + 2 + ADDR_WIDTH;

    // frame field positions, first received bit ends up at the MSB
    localparam int START_MSB = FRAME_BITS - 1;
    localparam int START_LSB = FRAME_BITS - START_BITS;
    localparam int ID_MSB    = START_LSB - 1;
    localparam int ID_LSB    = START_LSB - ID_WIDTH;
    localparam int RW_POS    = ID_LSB - 1;
    localparam int BURST_POS = RW_POS - 1;
    localparam int ADDR_MSB  = ADDR_WIDTH - 1;
    localparam int ADDR_LSB  = 0;

    // counter needs to hold DATA_WIDTH-1 and FRAME_BITS-1
    localparam int COUNT_WIDTH = $clog2(DATA_WIDTH) + 1;

    typedef logic [DATA_WIDTH-1:0]  data_t;
    typedef logic [ADDR_WIDTH-1:0]  addr_t;
    typedef logic [ID_WIDTH-1:0]    slave_id_t;
    typedef logic [COUNT_WIDTH-1:0] bit_count_t;

    typedef enum logic {
        COUNT_FRAME,
        COUNT_WORD
    } count_mode_t;

    typedef enum logic [2:0] {
        IDLE,
        FRAME,
        DECODE,
        READ_FETCH,
        READ_LOAD,
        READ_SHIFT,
        WRITE_SHIFT,
        WRITE_STORE
    } slave_state_t;

endpackage

`default_nettype wire
